/* riscv_defines.svh */
`ifndef RISCV_DEFINES_SVH
`define RISCV_DEFINES_SVH

// Integer register and datapath width
`define RISCV_XLEN 64

// Instruction buffer entries, equal to the credits the source holds after reset
`define RISCV_BUF_DEPTH 4

// Output credit counter width, the consumer keeps at most 15 credits ungranted
`define RISCV_CREDIT_W 4

// The only CSR with storage behind it
`define RISCV_CSR_MSCRATCH 12'h340

`endif

/* riscv_pkg.sv */
package riscv_pkg;

  // Major opcodes handled by the decoder
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_SYSTEM = 7'b1110011
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B    // Second operand straight through, used by LUI
  } alu_op_t;

  typedef enum logic [2:0] {
    IMM_I,
    IMM_ISHAMT,
    IMM_U
  } imm_src_t;

  // Selects operand b for the ALU and the write source for CSR swaps
  typedef enum logic [1:0] {
    SRC_REG,
    SRC_IMM,
    SRC_ZIMM
  } op_src_t;

endpackage

/* riscv_fetch_buffer.sv */
`timescale 1ns/1ps
`include "riscv_defines.svh"

module riscv_fetch_buffer (
  input  logic        i_clk_n,
  input  logic        i_reset,
  input  logic        i_inst_valid,
  input  logic [31:0] i_inst,
  input  logic        i_advance,
  output logic        o_head_valid,
  output logic [31:0] o_head,
  output logic        o_inst_credit
);

  localparam int DEPTH = `RISCV_BUF_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  logic [31:0]    mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic           pop;

  assign pop = i_advance && (count != '0);    // Head leaves into decode/execute

  assign o_head_valid  = (count != '0);
  assign o_head        = mem[rd_ptr];
  assign o_inst_credit = pop;                 // One credit back per released instruction

  // The source never sends without a credit, so a push always finds room
  always_ff @(posedge i_clk_n) begin
    if (i_inst_valid) begin
      mem[wr_ptr] <= i_inst;
    end
  end

  always_ff @(posedge i_clk_n) begin
    if (i_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_inst_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({i_inst_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;    // Push and pop together leave the fill level alone
      endcase
    end
  end

endmodule

/* riscv_rf.sv */
`timescale 1ns/1ps
`include "riscv_defines.svh"

module riscv_rf (
  input  logic                   i_clk_n,
  input  logic                   i_reset,
  input  logic                   i_regwrite,
  input  logic [4:0]             i_rs1addr,
  input  logic [4:0]             i_rs2addr,
  input  logic [4:0]             i_rdaddr,
  input  logic [`RISCV_XLEN-1:0] i_rddata,
  output logic [`RISCV_XLEN-1:0] o_rs1data,
  output logic [`RISCV_XLEN-1:0] o_rs2data
);

  logic [`RISCV_XLEN-1:0] regs [32];

  // Writing on the falling edge lets decode see a writeback in the same cycle
  always_ff @(negedge i_clk_n) begin
    if (i_reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_regwrite && (i_rdaddr != 5'd0)) begin
      regs[i_rdaddr] <= i_rddata;
    end
  end

  assign o_rs1data = regs[i_rs1addr];    // x0 is never written and stays zero
  assign o_rs2data = regs[i_rs2addr];

endmodule

/* riscv_extend.sv */
`timescale 1ns/1ps
`include "riscv_defines.svh"

module riscv_extend (
  input  riscv_pkg::imm_src_t    i_immsrc,
  input  logic [31:7]            i_inst,
  output logic [`RISCV_XLEN-1:0] o_simm,
  output logic [`RISCV_XLEN-1:0] o_immzeroextend
);

  import riscv_pkg::*;

  always_comb begin
    case (i_immsrc)
      IMM_I: begin
        o_simm = {{(`RISCV_XLEN-12){i_inst[31]}}, i_inst[31:20]};
      end
      IMM_ISHAMT: begin
        // RV64 shift amounts are six bits wide
        o_simm = {{(`RISCV_XLEN-6){1'b0}}, i_inst[25:20]};
      end
      IMM_U: begin
        o_simm = {{(`RISCV_XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
      end
      default: begin
        o_simm = '0;
      end
    endcase
  end

  // The rs1 field doubles as the CSRRWI source
  assign o_immzeroextend = {{(`RISCV_XLEN-5){1'b0}}, i_inst[19:15]};

endmodule

/* riscv_dstage.sv */
`timescale 1ns/1ps
`include "riscv_defines.svh"

module riscv_dstage (
  input  logic                   i_clk_n,
  input  logic                   i_reset,
  input  logic                   i_advance,
  input  logic                   i_head_valid,
  input  logic [31:0]            i_inst,
  input  logic                   i_regw,
  input  logic [4:0]             i_rdaddr_wb,
  input  logic [`RISCV_XLEN-1:0] i_rddata_wb,
  output logic                   o_valid,
  output logic [`RISCV_XLEN-1:0] o_rs1data,
  output logic [`RISCV_XLEN-1:0] o_rs2data,
  output logic [4:0]             o_rs1addr,
  output logic [4:0]             o_rs2addr,
  output logic [4:0]             o_rdaddr,
  output logic [`RISCV_XLEN-1:0] o_simm,
  output logic [`RISCV_XLEN-1:0] o_immzeroextend,
  output riscv_pkg::alu_op_t     o_aluop,
  output riscv_pkg::op_src_t     o_opsrc,
  output logic                   o_is_csr,
  output logic [11:0]            o_csr_addr,
  output logic                   o_illegal
);

  import riscv_pkg::*;

  opcode_t                opcode;
  logic [2:0]             funct3;
  logic                   funct7_0;
  logic                   funct7_5;
  alu_op_t                aluop;
  op_src_t                opsrc;
  imm_src_t               immsrc;
  logic                   is_csr;
  logic                   illegal;
  logic [`RISCV_XLEN-1:0] rs1data;
  logic [`RISCV_XLEN-1:0] rs2data;
  logic [`RISCV_XLEN-1:0] simm;
  logic [`RISCV_XLEN-1:0] zimm;

  assign opcode   = opcode_t'(i_inst[6:0]);
  assign funct3   = i_inst[14:12];
  assign funct7_0 = i_inst[25];
  assign funct7_5 = i_inst[30];

  // Shared funct3 mapping of OP and OP-IMM, alt picks SUB or SRA
  function automatic alu_op_t alu_from_funct3(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  always_comb begin
    aluop   = ALU_ADD;
    opsrc   = SRC_REG;
    immsrc  = IMM_I;
    is_csr  = 1'b0;
    illegal = 1'b0;
    case (opcode)
      OPC_OP: begin
        aluop = alu_from_funct3(funct3, funct7_5);
        // Bit 0 would be the M extension, bit 5 is only valid for sub and sra
        if (funct7_0 || (funct7_5 && funct3 != 3'b000 && funct3 != 3'b101)) begin
          illegal = 1'b1;
        end
      end
      OPC_OP_IMM: begin
        opsrc = SRC_IMM;
        aluop = alu_from_funct3(funct3, funct7_5 && (funct3 == 3'b101));
        if (funct3 == 3'b001 || funct3 == 3'b101) begin
          immsrc = IMM_ISHAMT;
        end
        if ((funct3 == 3'b001 && i_inst[31:26] != 6'd0) ||
            (funct3 == 3'b101 && {i_inst[31], i_inst[29:26]} != 5'd0)) begin
          illegal = 1'b1;    // Bad upper bits on an immediate shift
        end
      end
      OPC_LUI: begin
        aluop  = ALU_PASS_B;
        opsrc  = SRC_IMM;
        immsrc = IMM_U;
      end
      OPC_SYSTEM: begin
        is_csr = 1'b1;
        if (funct3 == 3'b001) begin
          opsrc = SRC_REG;     // CSRRW
        end else if (funct3 == 3'b101) begin
          opsrc = SRC_ZIMM;    // CSRRWI
        end else begin
          is_csr  = 1'b0;
          illegal = 1'b1;
        end
      end
      default: illegal = 1'b1;
    endcase
  end

  riscv_rf u_riscv_rf (
    .i_clk_n    (i_clk_n),
    .i_reset    (i_reset),
    .i_regwrite (i_regw),
    .i_rs1addr  (i_inst[19:15]),
    .i_rs2addr  (i_inst[24:20]),
    .i_rdaddr   (i_rdaddr_wb),
    .i_rddata   (i_rddata_wb),
    .o_rs1data  (rs1data),
    .o_rs2data  (rs2data)
  );

  riscv_extend u_riscv_extend (
    .i_immsrc        (immsrc),
    .i_inst          (i_inst[31:7]),
    .o_simm          (simm),
    .o_immzeroextend (zimm)
  );

  always_ff @(posedge i_clk_n) begin
    if (i_reset) begin
      o_valid <= 1'b0;
    end else if (i_advance) begin
      o_valid <= i_head_valid;    // Empty buffer loads a bubble
    end
  end

  always_ff @(posedge i_clk_n) begin
    if (i_advance) begin
      o_rs1data       <= rs1data;
      o_rs2data       <= rs2data;
      o_rs1addr       <= i_inst[19:15];
      o_rs2addr       <= i_inst[24:20];
      o_rdaddr        <= i_inst[11:7];
      o_simm          <= simm;
      o_immzeroextend <= zimm;
      o_aluop         <= aluop;
      o_opsrc         <= opsrc;
      o_is_csr        <= is_csr;
      o_csr_addr      <= i_inst[31:20];
      o_illegal       <= illegal;
    end
  end

endmodule

/* riscv_estage.sv */
`timescale 1ns/1ps
`include "riscv_defines.svh"

module riscv_estage (
  input  logic                      i_clk_n,
  input  logic                      i_reset,
  input  logic                      i_res_credit,
  input  logic                      i_valid,
  input  logic [`RISCV_XLEN-1:0]    i_rs1data,
  input  logic [`RISCV_XLEN-1:0]    i_rs2data,
  input  logic [4:0]                i_rs1addr,
  input  logic [4:0]                i_rs2addr,
  input  logic [4:0]                i_rdaddr,
  input  logic [`RISCV_XLEN-1:0]    i_simm,
  input  logic [`RISCV_XLEN-1:0]    i_immzeroextend,
  input  riscv_pkg::alu_op_t        i_aluop,
  input  riscv_pkg::op_src_t        i_opsrc,
  input  logic                      i_is_csr,
  input  logic [11:0]               i_csr_addr,
  input  logic                      i_illegal,
  output logic                      o_advance,
  output logic                      o_regw,
  output logic [4:0]                o_rdaddr_wb,
  output logic [`RISCV_XLEN-1:0]    o_rddata_wb,
  output logic                      o_res_valid,
  output logic [4:0]                o_res_rd,
  output logic [`RISCV_XLEN-1:0]    o_res_data,
  output logic                      o_res_illegal
);

  import riscv_pkg::*;

  logic                      ew_valid;
  logic [4:0]                ew_rd;
  logic [`RISCV_XLEN-1:0]    ew_data;
  logic                      ew_illegal;
  logic [`RISCV_CREDIT_W-1:0] credit_cnt;
  logic [`RISCV_XLEN-1:0]    mscratch;
  logic [`RISCV_XLEN-1:0]    op_a;
  logic [`RISCV_XLEN-1:0]    rs2_fwd;
  logic [`RISCV_XLEN-1:0]    op_b;
  logic [5:0]                shamt;
  logic [`RISCV_XLEN-1:0]    alu_res;
  logic                      csr_hit;
  logic [`RISCV_XLEN-1:0]    csr_rdata;
  logic [`RISCV_XLEN-1:0]    csr_wdata;
  logic [`RISCV_XLEN-1:0]    result;

  // Forward the older result still waiting in execute/writeback
  assign op_a    = (o_regw && ew_rd == i_rs1addr) ? ew_data : i_rs1data;
  assign rs2_fwd = (o_regw && ew_rd == i_rs2addr) ? ew_data : i_rs2data;

  always_comb begin
    case (i_opsrc)
      SRC_IMM:  op_b = i_simm;
      default:  op_b = rs2_fwd;
    endcase
  end

  assign shamt = op_b[5:0];

  always_comb begin
    case (i_aluop)
      ALU_ADD:  alu_res = op_a + op_b;
      ALU_SUB:  alu_res = op_a - op_b;
      ALU_SLL:  alu_res = op_a << shamt;
      ALU_SLT:  alu_res = {{(`RISCV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_res = {{(`RISCV_XLEN-1){1'b0}}, op_a < op_b};
      ALU_XOR:  alu_res = op_a ^ op_b;
      ALU_SRL:  alu_res = op_a >> shamt;
      ALU_SRA:  alu_res = $signed(op_a) >>> shamt;
      ALU_OR:   alu_res = op_a | op_b;
      ALU_AND:  alu_res = op_a & op_b;
      default:  alu_res = op_b;
    endcase
  end

  // Every CSR address other than mscratch reads zero and drops writes
  assign csr_hit   = (i_csr_addr == `RISCV_CSR_MSCRATCH);
  assign csr_rdata = csr_hit ? mscratch : '0;
  assign csr_wdata = (i_opsrc == SRC_ZIMM) ? i_immzeroextend : op_a;

  assign result = i_illegal ? '0 : (i_is_csr ? csr_rdata : alu_res);

  always_ff @(posedge i_clk_n) begin
    if (i_reset) begin
      mscratch <= '0;
    end else if (o_advance && i_valid && i_is_csr && csr_hit) begin
      mscratch <= csr_wdata;    // The old value goes to rd in the same swap
    end
  end

  always_ff @(posedge i_clk_n) begin
    if (i_reset) begin
      ew_valid <= 1'b0;
    end else if (o_advance) begin
      ew_valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk_n) begin
    if (o_advance) begin
      ew_rd      <= i_rdaddr;
      ew_data    <= result;
      ew_illegal <= i_illegal;
    end
  end

  // A result leaves only against a credit granted by the consumer
  assign o_res_valid = ew_valid && (credit_cnt != '0);
  assign o_advance   = !ew_valid || (credit_cnt != '0);

  always_ff @(posedge i_clk_n) begin
    if (i_reset) begin
      credit_cnt <= '0;
    end else begin
      case ({i_res_credit, o_res_valid})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  assign o_regw        = ew_valid && !ew_illegal && (ew_rd != 5'd0);
  assign o_rdaddr_wb   = ew_rd;
  assign o_rddata_wb   = ew_data;
  assign o_res_rd      = ew_rd;
  assign o_res_data    = ew_data;
  assign o_res_illegal = ew_illegal;

endmodule

/* riscv_core_top.sv */
`timescale 1ns/1ps
`include "riscv_defines.svh"

module riscv_core_top (
  input  logic                   i_clk_n,
  input  logic                   i_reset,
  input  logic                   i_inst_valid,
  input  logic [31:0]            i_inst,
  input  logic                   i_res_credit,
  output logic                   o_inst_credit,
  output logic                   o_res_valid,
  output logic [4:0]             o_res_rd,
  output logic [`RISCV_XLEN-1:0] o_res_data,
  output logic                   o_res_illegal
);

  import riscv_pkg::*;

  logic                   advance;
  logic                   head_valid;
  logic [31:0]            head;
  logic                   regw;
  logic [4:0]             rdaddr_wb;
  logic [`RISCV_XLEN-1:0] rddata_wb;
  logic                   de_valid;
  logic [`RISCV_XLEN-1:0] de_rs1data;
  logic [`RISCV_XLEN-1:0] de_rs2data;
  logic [4:0]             de_rs1addr;
  logic [4:0]             de_rs2addr;
  logic [4:0]             de_rdaddr;
  logic [`RISCV_XLEN-1:0] de_simm;
  logic [`RISCV_XLEN-1:0] de_zimm;
  alu_op_t                de_aluop;
  op_src_t                de_opsrc;
  logic                   de_is_csr;
  logic [11:0]            de_csr_addr;
  logic                   de_illegal;

  riscv_fetch_buffer u_riscv_fetch_buffer (
    .i_clk_n       (i_clk_n),
    .i_reset       (i_reset),
    .i_inst_valid  (i_inst_valid),
    .i_inst        (i_inst),
    .i_advance     (advance),
    .o_head_valid  (head_valid),
    .o_head        (head),
    .o_inst_credit (o_inst_credit)
  );

  riscv_dstage u_riscv_dstage (
    .i_clk_n         (i_clk_n),
    .i_reset         (i_reset),
    .i_advance       (advance),
    .i_head_valid    (head_valid),
    .i_inst          (head),
    .i_regw          (regw),
    .i_rdaddr_wb     (rdaddr_wb),
    .i_rddata_wb     (rddata_wb),
    .o_valid         (de_valid),
    .o_rs1data       (de_rs1data),
    .o_rs2data       (de_rs2data),
    .o_rs1addr       (de_rs1addr),
    .o_rs2addr       (de_rs2addr),
    .o_rdaddr        (de_rdaddr),
    .o_simm          (de_simm),
    .o_immzeroextend (de_zimm),
    .o_aluop         (de_aluop),
    .o_opsrc         (de_opsrc),
    .o_is_csr        (de_is_csr),
    .o_csr_addr      (de_csr_addr),
    .o_illegal       (de_illegal)
  );

  riscv_estage u_riscv_estage (
    .i_clk_n         (i_clk_n),
    .i_reset         (i_reset),
    .i_res_credit    (i_res_credit),
    .i_valid         (de_valid),
    .i_rs1data       (de_rs1data),
    .i_rs2data       (de_rs2data),
    .i_rs1addr       (de_rs1addr),
    .i_rs2addr       (de_rs2addr),
    .i_rdaddr        (de_rdaddr),
    .i_simm          (de_simm),
    .i_immzeroextend (de_zimm),
    .i_aluop         (de_aluop),
    .i_opsrc         (de_opsrc),
    .i_is_csr        (de_is_csr),
    .i_csr_addr      (de_csr_addr),
    .i_illegal       (de_illegal),
    .o_advance       (advance),
    .o_regw          (regw),
    .o_rdaddr_wb     (rdaddr_wb),
    .o_rddata_wb     (rddata_wb),
    .o_res_valid     (o_res_valid),
    .o_res_rd        (o_res_rd),
    .o_res_data      (o_res_data),
    .o_res_illegal   (o_res_illegal)
  );

endmodule

/* riscv_tb.sv */
`timescale 1ns/1ps
`include "riscv_defines.svh"

module riscv_tb;

  localparam int N_ROWS     = 34;
  localparam int MAX_CYCLES = N_ROWS * 40 + 100;
  localparam int MAX_GRANTS = 15;                     // Output credit counter holds at most 15
  localparam logic [31:0] GRANT_LEVEL = 32'h5000_0000;

  localparam logic [6:0] OP     = 7'b0110011;
  localparam logic [6:0] OP_IMM = 7'b0010011;
  localparam logic [6:0] LUI    = 7'b0110111;
  localparam logic [6:0] SYSTEM = 7'b1110011;
  localparam logic [6:0] LOAD   = 7'b0000011;         // Not implemented, must come back illegal

  logic                   clk          = 1'b0;
  logic                   i_reset      = 1'b1;
  logic                   i_inst_valid = 1'b0;
  logic [31:0]            i_inst       = 32'h0;
  logic                   i_res_credit = 1'b0;
  logic                   o_inst_credit;
  logic                   o_res_valid;
  logic [4:0]             o_res_rd;
  logic [`RISCV_XLEN-1:0] o_res_data;
  logic                   o_res_illegal;

  // Stimulus table with the hand-computed results
  logic [31:0]            tbl_inst [N_ROWS];
  logic [4:0]             tbl_rd   [N_ROWS];
  logic [`RISCV_XLEN-1:0] tbl_data [N_ROWS];
  logic                   tbl_ill  [N_ROWS];
  int                     rows_filled = 0;

  int          sent            = 0;
  int          returned        = 0;
  int          grants          = 0;
  int          results         = 0;
  int          cycles          = 0;
  int          value_errors    = 0;
  int          protocol_errors = 0;
  int          run_errors      = 0;
  logic [31:0] rng_state       = 32'hbb08_354d;

  always #10 clk = ~clk;

  riscv_core_top uut (
    .i_clk_n       (clk),
    .i_reset       (i_reset),
    .i_inst_valid  (i_inst_valid),
    .i_inst        (i_inst),
    .i_res_credit  (i_res_credit),
    .o_inst_credit (o_inst_credit),
    .o_res_valid   (o_res_valid),
    .o_res_rd      (o_res_rd),
    .o_res_data    (o_res_data),
    .o_res_illegal (o_res_illegal)
  );

  function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP};
  endfunction

  function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] utype(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, LUI};
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int credits_left();
    return `RISCV_BUF_DEPTH - sent + returned;
  endfunction

  task automatic add_row(input logic [31:0] inst, input logic [4:0] rd,
                         input logic [`RISCV_XLEN-1:0] data, input logic ill);
    if (rows_filled < N_ROWS) begin
      tbl_inst[rows_filled] = inst;
      tbl_rd[rows_filled]   = rd;
      tbl_data[rows_filled] = data;
      tbl_ill[rows_filled]  = ill;
    end
    rows_filled++;
  endtask

  task automatic build_table();
    // Constants, including negative immediates
    add_row(itype(12'd5, 5'd0, 3'b000, 5'd1, OP_IMM), 5'd1, 64'h5, 1'b0);
    add_row(itype(12'hFFD, 5'd0, 3'b000, 5'd2, OP_IMM), 5'd2, 64'hFFFF_FFFF_FFFF_FFFD, 1'b0);
    add_row(utype(20'h80000, 5'd3), 5'd3, 64'hFFFF_FFFF_8000_0000, 1'b0);
    add_row(utype(20'h12345, 5'd4), 5'd4, 64'h0000_0000_1234_5000, 1'b0);
    add_row(itype(12'hF9C, 5'd1, 3'b000, 5'd23, OP_IMM), 5'd23, 64'hFFFF_FFFF_FFFF_FFA1, 1'b0);
    // Dependent R-type chain, one back uses the bypass and two back the register file
    add_row(rtype(7'h00, 5'd2, 5'd1, 3'b000, 5'd5), 5'd5, 64'h2, 1'b0);
    add_row(rtype(7'h20, 5'd1, 5'd5, 3'b000, 5'd6), 5'd6, 64'hFFFF_FFFF_FFFF_FFFD, 1'b0);
    add_row(rtype(7'h00, 5'd1, 5'd6, 3'b010, 5'd7), 5'd7, 64'h1, 1'b0);
    add_row(rtype(7'h00, 5'd7, 5'd6, 3'b011, 5'd8), 5'd8, 64'h0, 1'b0);
    add_row(rtype(7'h00, 5'd7, 5'd6, 3'b100, 5'd9), 5'd9, 64'hFFFF_FFFF_FFFF_FFFC, 1'b0);
    add_row(rtype(7'h00, 5'd4, 5'd9, 3'b111, 5'd10), 5'd10, 64'h0000_0000_1234_5000, 1'b0);
    add_row(rtype(7'h00, 5'd1, 5'd10, 3'b110, 5'd11), 5'd11, 64'h0000_0000_1234_5005, 1'b0);
    add_row(rtype(7'h00, 5'd1, 5'd11, 3'b001, 5'd12), 5'd12, 64'h0000_0002_468A_00A0, 1'b0);
    add_row(rtype(7'h00, 5'd1, 5'd3, 3'b101, 5'd13), 5'd13, 64'h07FF_FFFF_FC00_0000, 1'b0);
    add_row(rtype(7'h20, 5'd1, 5'd3, 3'b101, 5'd14), 5'd14, 64'hFFFF_FFFF_FC00_0000, 1'b0);
    // Immediate forms, shift amounts above 31 included
    add_row(itype(12'd40, 5'd1, 3'b001, 5'd15, OP_IMM), 5'd15, 64'h0000_0500_0000_0000, 1'b0);
    add_row(itype(12'h404, 5'd3, 3'b101, 5'd16, OP_IMM), 5'd16, 64'hFFFF_FFFF_F800_0000, 1'b0);
    add_row(itype(12'd33, 5'd15, 3'b101, 5'd17, OP_IMM), 5'd17, 64'h280, 1'b0);
    add_row(itype(12'hFFF, 5'd2, 3'b100, 5'd18, OP_IMM), 5'd18, 64'h2, 1'b0);
    add_row(itype(12'h0AB, 5'd4, 3'b110, 5'd19, OP_IMM), 5'd19, 64'h1234_50AB, 1'b0);
    add_row(itype(12'h0FF, 5'd19, 3'b111, 5'd20, OP_IMM), 5'd20, 64'hAB, 1'b0);
    add_row(itype(12'hFFF, 5'd1, 3'b011, 5'd21, OP_IMM), 5'd21, 64'h1, 1'b0);
    add_row(itype(12'hFFE, 5'd2, 3'b010, 5'd22, OP_IMM), 5'd22, 64'h1, 1'b0);
    // CSR swaps return the previous mscratch value
    add_row(itype(`RISCV_CSR_MSCRATCH, 5'd21, 3'b101, 5'd24, SYSTEM), 5'd24, 64'h0, 1'b0);
    add_row(itype(`RISCV_CSR_MSCRATCH, 5'd4, 3'b001, 5'd25, SYSTEM), 5'd25, 64'h15, 1'b0);
    add_row(itype(`RISCV_CSR_MSCRATCH, 5'd1, 3'b001, 5'd26, SYSTEM), 5'd26, 64'h1234_5000, 1'b0);
    add_row(itype(12'h341, 5'd7, 3'b101, 5'd27, SYSTEM), 5'd27, 64'h0, 1'b0);
    add_row(itype(`RISCV_CSR_MSCRATCH, 5'd0, 3'b001, 5'd28, SYSTEM), 5'd28, 64'h5, 1'b0);
    // x0 reports its data but keeps reading zero
    add_row(itype(12'd10, 5'd1, 3'b000, 5'd0, OP_IMM), 5'd0, 64'hF, 1'b0);
    add_row(rtype(7'h00, 5'd1, 5'd0, 3'b000, 5'd29), 5'd29, 64'h5, 1'b0);
    // Illegal encodings leave x30 untouched
    add_row(itype(12'd77, 5'd0, 3'b000, 5'd30, OP_IMM), 5'd30, 64'h4D, 1'b0);
    add_row(itype(12'd0, 5'd1, 3'b011, 5'd30, LOAD), 5'd30, 64'h0, 1'b1);
    add_row(rtype(7'h01, 5'd1, 5'd1, 3'b000, 5'd30), 5'd30, 64'h0, 1'b1);
    add_row(itype(12'd1, 5'd30, 3'b000, 5'd31, OP_IMM), 5'd31, 64'h4E, 1'b0);
  endtask

  task automatic compare_result(input int idx);
    assert (o_res_rd == tbl_rd[idx]) else begin
      value_errors++;
      $display("ERROR row %0d o_res_rd expected %h got %h", idx, tbl_rd[idx], o_res_rd);
    end
    assert (o_res_illegal == tbl_ill[idx]) else begin
      value_errors++;
      $display("ERROR row %0d o_res_illegal expected %h got %h", idx, tbl_ill[idx],
               o_res_illegal);
    end
    // An illegal instruction has no defined result data
    if (!tbl_ill[idx]) begin
      assert (o_res_data == tbl_data[idx]) else begin
        value_errors++;
        $display("ERROR row %0d o_res_data expected %h got %h", idx, tbl_data[idx],
                 o_res_data);
      end
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
  end

  // Source spends one credit per instruction it sends
  always @(posedge clk) begin
    if (!i_reset && sent < N_ROWS && credits_left() > 0) begin
      i_inst_valid <= 1'b1;
      i_inst       <= tbl_inst[sent];
      sent         <= sent + 1;
    end else begin
      i_inst_valid <= 1'b0;
    end
  end

  always @(posedge clk) begin
    rng_state = xorshift32(rng_state);
    if (!i_reset && rng_state < GRANT_LEVEL && grants - results < MAX_GRANTS) begin
      i_res_credit <= 1'b1;
      grants       <= grants + 1;
    end else begin
      i_res_credit <= 1'b0;
    end
  end

  // Outputs only change on the rising edge, so the falling edge sees them settled
  always @(negedge clk) begin
    if (!i_reset) begin
      if (o_inst_credit) begin
        returned = returned + 1;
        assert (returned <= sent) else begin
          protocol_errors++;
          $display("A credit came back for an instruction that was never sent");
        end
      end
      if (o_res_valid) begin
        assert (results < N_ROWS) else begin
          protocol_errors++;
          $display("An extra result arrived after every table row was answered");
        end
        if (results < N_ROWS) begin
          compare_result(results);
        end
        results = results + 1;
      end
    end
  end

  initial begin
    build_table();
    assert (rows_filled == N_ROWS) else begin
      run_errors++;
      $display("The stimulus table has %0d rows instead of %0d", rows_filled, N_ROWS);
    end
    repeat (2) @(posedge clk);
    i_reset <= 1'b0;
    while (results < N_ROWS && cycles < MAX_CYCLES) begin
      @(posedge clk);
    end
    assert (results >= N_ROWS) else begin
      run_errors++;
      $display("Timed out after %0d cycles, %0d of %0d results were missing", cycles,
               N_ROWS - results, N_ROWS);
    end
    repeat (10) @(posedge clk);    // Leaves room for a stray extra result to show up
    assert (sent == N_ROWS && returned == sent) else begin
      run_errors++;
      $display("Not all source credits came back, %0d sent and %0d returned", sent, returned);
    end
    $display("Errors: %0d value, %0d protocol, %0d end of run", value_errors,
             protocol_errors, run_errors);
    if (value_errors + protocol_errors + run_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+.
riscv_pkg.sv
riscv_fetch_buffer.sv
riscv_rf.sv
riscv_extend.sv
riscv_dstage.sv
riscv_estage.sv
riscv_core_top.sv
riscv_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps --top-module riscv_tb -f all.f -o riscv_sim
./obj_dir/riscv_sim | tee sim.log

if grep -qx '>>> PASS' sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
